// ==== logic/div_pkg.sv ====
package div_pkg;

  // ========================================
  // Datapath widths
  // ========================================

  // Dividend width. The top byte must stay below the divisor for the quotient to fit.
  localparam int N_W = 16;

  // Divisor, quotient and remainder width. This is also the row and column count of the array.
  localparam int D_W = 8;

  // Rows with an index below this use approximate cells.
  // Rows 0 to 5 produce the low quotient bits, so errors stay small there.
  localparam int APPROX_ROWS = 6;

  // ========================================
  // Control
  // ========================================

  typedef enum logic [1:0] {
    S_IDLE, // Waiting for start.
    S_EVAL, // Array settles, and the result is captured at the end of this state.
    S_DONE  // Result valid, done pulse.
  } div_state_e;

endpackage

// ==== logic/div_array.sv ====
`timescale 1ns/1ps

module div_array
  import div_pkg::*;
(
  input  logic [N_W-1:0] n_reg,
  input  logic [D_W-1:0] d_reg,
  output logic [D_W-1:0] q_arr,
  output logic [D_W-1:0] r_arr
);

  // ========================================
  // Cell rules, result packed as {bout, diff}
  // ========================================

  function automatic logic [1:0] exact_cell(input logic x, input logic y, input logic bin);
    logic diff;
    logic bout;
    diff = x ^ y ^ bin;
    bout = (~x & y) | (~(x ^ y) & bin);
    return {bout, diff};
  endfunction

  // Borrow ignores y and bin entirely.
  function automatic logic [1:0] approx_cell(input logic x, input logic y, input logic bin);
    logic diff;
    logic bout;
    diff = x & ~(y & bin);
    bout = ~x;
    return {bout, diff};
  endfunction

  // ========================================
  // Array rows
  // ========================================

  wire [D_W-1:0] x_row    [D_W]; // Minuend bits entering each row.
  wire [D_W-1:0] diff_row [D_W];
  wire [D_W-1:0] bout_row [D_W]; // Borrow chain, LSB cell first.
  wire [D_W-1:0] rem_row  [D_W]; // Partial remainder leaving each row.
  wire [D_W-1:0] top_bit;        // Dividend bit above each row's window.

  genvar i, j;

  generate
    for (i = 0; i < D_W; i++) begin : g_row
      // Row 7 sees the raw dividend, every lower row shifts in one new dividend bit.
      if (i == D_W - 1) begin : g_first
        assign x_row[i]   = n_reg[N_W-2:D_W-1];
        assign top_bit[i] = n_reg[N_W-1];
      end else begin : g_inner
        assign x_row[i]   = {rem_row[i+1][D_W-2:0], n_reg[i]};
        assign top_bit[i] = rem_row[i+1][D_W-1];
      end

      for (j = 0; j < D_W; j++) begin : g_cell
        wire bin;

        if (j == 0) begin : g_lsb
          assign bin = 1'b0;
        end else begin : g_chain
          assign bin = bout_row[i][j-1];
        end

        if (i < APPROX_ROWS) begin : g_approx
          assign {bout_row[i][j], diff_row[i][j]} = approx_cell(x_row[i][j], d_reg[j], bin);
        end else begin : g_exact
          assign {bout_row[i][j], diff_row[i][j]} = exact_cell(x_row[i][j], d_reg[j], bin);
        end
      end

      // No borrow out means the divisor fit, and a set bit above the window always fits.
      assign q_arr[i] = top_bit[i] | ~bout_row[i][D_W-1];

      // Restore when the divisor did not fit.
      assign rem_row[i] = q_arr[i] ? diff_row[i] : x_row[i];
    end
  endgenerate

  assign r_arr = rem_row[0]; // Bottom row holds the final remainder.

endmodule

// ==== logic/operand_capture.sv ====
`timescale 1ns/1ps

module operand_capture
  import div_pkg::*;
(
  input  logic           clk,
  input  logic           rst_n,
  input  logic           load,
  input  logic [N_W-1:0] n,
  input  logic [D_W-1:0] d,
  output logic [N_W-1:0] n_reg,
  output logic [D_W-1:0] d_reg,
  output logic           ovf_reg
);

  logic ovf_next;

  // ========================================
  // Overflow decision
  // ========================================

  // The quotient fits in D_W bits only when the high dividend byte is below the divisor.
  // A zero divisor fails that test too.
  always_comb begin
    ovf_next = (d == '0) || (n[N_W-1:D_W] >= d);
  end

  // ========================================
  // Operand registers
  // ========================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      n_reg   <= '0;
      d_reg   <= '0;
      ovf_reg <= 1'b0;
    end else if (load) begin
      n_reg   <= n;
      d_reg   <= d;
      ovf_reg <= ovf_next; // Travels with the operands to the result stage.
    end
  end

endmodule

// ==== logic/div_ctrl.sv ====
`timescale 1ns/1ps

module div_ctrl
  import div_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic start,
  output logic load,
  output logic hold,
  output logic busy,
  output logic done
);

  div_state_e state;
  div_state_e state_next;

  // ========================================
  // State register
  // ========================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= S_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // One evaluation cycle is enough for the array, so the sequence never waits.
  always_comb begin
    state_next = state;
    case (state)
      S_IDLE: begin
        if (start) begin
          state_next = S_EVAL;
        end
      end
      S_EVAL:  state_next = S_DONE;
      S_DONE:  state_next = S_IDLE;
      default: state_next = S_IDLE;
    endcase
  end

  // ========================================
  // Output decode
  // ========================================

  always_comb begin
    load = (state == S_IDLE) && start; // Starts seen while busy are dropped.
    hold = (state == S_EVAL);
    busy = (state != S_IDLE);
    done = (state == S_DONE);
  end

  // Each accepted division gives exactly one done pulse.
  assert property (@(posedge clk) disable iff (!rst_n)
    done |=> !done)
    else $error("done held high for two cycles");

  // A new operand capture would corrupt a division in flight.
  assert property (@(posedge clk) disable iff (!rst_n)
    !(load && busy))
    else $error("load fired while busy");

endmodule

// ==== logic/result_hold.sv ====
`timescale 1ns/1ps

module result_hold
  import div_pkg::*;
(
  input  logic           clk,
  input  logic           rst_n,
  input  logic           hold,
  input  logic [D_W-1:0] q_arr,
  input  logic [D_W-1:0] r_arr,
  input  logic           ovf_reg,
  output logic [D_W-1:0] q,
  output logic [D_W-1:0] r,
  output logic           ovf
);

  // ========================================
  // Result registers
  // ========================================

  // Captured once per division, at the end of the evaluation cycle.
  // Overflow results are delivered as the array computed them.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      q   <= '0;
      r   <= '0;
      ovf <= 1'b0;
    end else if (hold) begin
      q   <= q_arr;
      r   <= r_arr;
      ovf <= ovf_reg;
    end
  end

  // Outputs only move on a capture, so they stay steady through idle gaps.
  assert property (@(posedge clk) disable iff (!rst_n)
    !hold |=> $stable({q, r, ovf}))
    else $error("result outputs changed without a capture");

endmodule

// ==== logic/approx_div_top.sv ====
`timescale 1ns/1ps

module approx_div_top
  import div_pkg::*;
(
  input  logic           clk,
  input  logic           rst_n,
  input  logic           start,
  input  logic [N_W-1:0] n,
  input  logic [D_W-1:0] d,
  output logic [D_W-1:0] q,
  output logic [D_W-1:0] r,
  output logic           ovf,
  output logic           busy,
  output logic           done
);

  logic           load;
  logic           hold;
  logic [N_W-1:0] n_reg;
  logic [D_W-1:0] d_reg;
  logic           ovf_reg;
  logic [D_W-1:0] q_arr;
  logic [D_W-1:0] r_arr;

  // ========================================
  // Control and datapath
  // ========================================

  div_ctrl ctrl_i (
    .clk   (clk),
    .rst_n (rst_n),
    .start (start),
    .load  (load),
    .hold  (hold),
    .busy  (busy),
    .done  (done)
  );

  operand_capture capture_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .load    (load),
    .n       (n),
    .d       (d),
    .n_reg   (n_reg),
    .d_reg   (d_reg),
    .ovf_reg (ovf_reg)
  );

  div_array array_i (
    .n_reg (n_reg),
    .d_reg (d_reg),
    .q_arr (q_arr),
    .r_arr (r_arr)
  );

  result_hold hold_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .hold    (hold),
    .q_arr   (q_arr),
    .r_arr   (r_arr),
    .ovf_reg (ovf_reg),
    .q       (q),
    .r       (r),
    .ovf     (ovf)
  );

endmodule

// ==== test/div_checker.sv ====
`timescale 1ns/1ps

module div_checker
  import div_pkg::*;
(
  input  logic           clk,
  input  logic           rst_n,
  input  logic           start,
  input  logic [N_W-1:0] n,
  input  logic [D_W-1:0] d,
  input  logic [D_W-1:0] q,
  input  logic [D_W-1:0] r,
  input  logic           ovf,
  input  logic           busy,
  input  logic           done,
  output int             errors,
  output int             divisions,
  output int             exact_cases
);

  int             phase;    // 0 idle, 1 evaluating, 2 done expected.
  logic [N_W-1:0] n_lat;
  logic [D_W-1:0] d_lat;
  logic [D_W-1:0] held_q;
  logic [D_W-1:0] held_r;
  logic           held_ovf;

  // ========================================
  // Array model
  // ========================================

  // Restoring array, row 7 first. Rows below approx_rows use the approximate cell.
  function automatic logic [2*D_W-1:0] array_model(input logic [N_W-1:0] num,
                                                   input logic [D_W-1:0] den,
                                                   input int approx_rows);
    logic [D_W-1:0] rem;
    logic [D_W-1:0] x;
    logic [D_W-1:0] diff;
    logic [D_W-1:0] quo;
    logic           top;
    logic           b;
    logic           b_next;
    int             i;
    int             j;
    rem = '0;
    quo = '0;
    for (i = D_W - 1; i >= 0; i--) begin
      if (i == D_W - 1) begin
        x   = num[N_W-2:D_W-1];
        top = num[N_W-1];
      end else begin
        x   = {rem[D_W-2:0], num[i]};
        top = rem[D_W-1];
      end
      b = 1'b0;
      for (j = 0; j < D_W; j++) begin
        if (i < approx_rows) begin
          diff[j] = x[j] & ~(den[j] & b);
          b_next  = ~x[j];
        end else begin
          diff[j] = x[j] ^ den[j] ^ b;
          b_next  = (~x[j] & den[j]) | (~x[j] & b) | (den[j] & b);
        end
        b = b_next;
      end
      quo[i] = top | ~b;
      rem    = quo[i] ? diff : x;
    end
    return {quo, rem};
  endfunction

  task automatic protocol_error(input string what);
    errors++;
    $display("[%0t] %s", $time, what);
  endtask

  task automatic compare(input string name, input logic [D_W-1:0] exp,
                         input logic [D_W-1:0] act);
    if (act !== exp) begin
      errors++;
      $display("mismatch %s at %0t: expected 0x%h, got 0x%h", name, $time, exp, act);
    end
  endtask

  task automatic check_held();
    compare("q", held_q, q);
    compare("r", held_r, r);
    compare("ovf", {7'b0, held_ovf}, {7'b0, ovf});
  endtask

  task automatic check_result();
    logic [2*D_W-1:0] approx;
    logic [2*D_W-1:0] exact;
    logic             exp_ovf;
    exp_ovf = (d_lat == '0) || (n_lat[N_W-1:D_W] >= d_lat);
    approx  = array_model(n_lat, d_lat, APPROX_ROWS);
    exact   = array_model(n_lat, d_lat, 0);
    compare("q", approx[2*D_W-1:D_W], q);
    compare("r", approx[D_W-1:0], r);
    compare("ovf", {7'b0, exp_ovf}, {7'b0, ovf});
    // When the approximate rows happen to agree, the result is true division.
    if (!exp_ovf && approx == exact) begin
      compare("q_exact", D_W'(n_lat / d_lat), q);
      compare("r_exact", D_W'(n_lat % d_lat), r);
      exact_cases++;
    end
    held_q   = approx[2*D_W-1:D_W];
    held_r   = approx[D_W-1:0];
    held_ovf = exp_ovf;
    divisions++;
  endtask

  // ========================================
  // Sequence tracking
  // ========================================

  initial begin
    errors      = 0;
    divisions   = 0;
    exact_cases = 0;
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase    = 0;
      held_q   = '0;
      held_r   = '0;
      held_ovf = 1'b0;
    end else begin
      case (phase)
        0: begin
          if (busy !== 1'b0) protocol_error("busy is high with no division in flight");
          if (done !== 1'b0) protocol_error("done pulsed with no division in flight");
          check_held();
          if (start === 1'b1) begin
            n_lat = n;
            d_lat = d;
            phase = 1;
          end
        end
        1: begin
          if (busy !== 1'b1) protocol_error("busy is low in the evaluation cycle");
          if (done !== 1'b0) protocol_error("done rose before the evaluation cycle ended");
          check_held(); // Results must not move before done.
          phase = 2;
        end
        default: begin
          if (busy !== 1'b1) protocol_error("busy is low while done is expected");
          if (done !== 1'b1) protocol_error("done did not rise one cycle after start");
          check_result();
          phase = 0;
        end
      endcase
    end
  end

endmodule

// ==== test/tb_approx_div.sv ====
`timescale 1ns/1ps

module tb_approx_div
  import div_pkg::*;
();

  localparam int NUM_DIVISIONS  = 400;
  localparam int MAX_GAP        = 4;
  localparam int TIMEOUT_CYCLES = NUM_DIVISIONS * (3 + MAX_GAP) + 200;
  localparam logic [31:0] SEED  = 32'h630d_d5e1;

  logic           clk;
  logic           rst_n;
  logic           start;
  logic [N_W-1:0] n;
  logic [D_W-1:0] d;
  logic [D_W-1:0] q;
  logic [D_W-1:0] r;
  logic           ovf;
  logic           busy;
  logic           done;
  int             errors;
  int             divisions;
  int             exact_cases;
  int             run_errors;
  int             cycle_count = 0;

  // ========================================
  // DUT and checker
  // ========================================

  approx_div_top dut_i (
    .clk(clk), .rst_n(rst_n), .start(start), .n(n), .d(d),
    .q(q), .r(r), .ovf(ovf), .busy(busy), .done(done)
  );

  div_checker checker_i (
    .clk(clk), .rst_n(rst_n), .start(start), .n(n), .d(d),
    .q(q), .r(r), .ovf(ovf), .busy(busy), .done(done),
    .errors(errors), .divisions(divisions), .exact_cases(exact_cases)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles with %0d errors", cycle_count, errors);
      $display("Checks failed");
      $finish;
    end
  end

  // ========================================
  // Stimulus
  // ========================================

  // About one case in eight cannot fit the quotient.
  task automatic pick_operands(output logic [N_W-1:0] num, output logic [D_W-1:0] den);
    logic [D_W-1:0] high;
    if ($urandom_range(7, 0) == 0) begin
      den  = ($urandom_range(1, 0) == 0) ? '0 : D_W'($urandom_range(255, 1));
      high = D_W'($urandom_range(255, den));
    end else begin
      den  = D_W'($urandom_range(255, 1));
      high = D_W'($urandom_range(den - 1, 0));
    end
    num = {high, D_W'($urandom())};
  endtask

  task automatic stray_start();
    logic [N_W-1:0] num;
    logic [D_W-1:0] den;
    pick_operands(num, den);
    n     = num;
    d     = den;
    start = 1'b1; // Must be ignored, the unit is busy.
  endtask

  task automatic run_division();
    logic [N_W-1:0] num;
    logic [D_W-1:0] den;
    int             inject;
    pick_operands(num, den);
    n      = num;
    d      = den;
    start  = 1'b1;
    inject = $urandom_range(2, 0);
    @(negedge clk);
    start = 1'b0;
    if (inject == 1) stray_start();
    while (done !== 1'b1) begin
      @(negedge clk);
      start = 1'b0;
    end
    if (inject == 2) stray_start();
    @(negedge clk);
    start = 1'b0;
    repeat ($urandom_range(MAX_GAP, 0)) @(negedge clk);
  endtask

  initial begin
    int k;
    rst_n      = 1'b0;
    start      = 1'b0;
    n          = '0;
    d          = '0;
    run_errors = 0;
    void'($urandom(SEED));
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    repeat (3) @(negedge clk); // Idle outputs are checked against zero here.
    for (k = 0; k < NUM_DIVISIONS; k++) begin
      run_division();
    end
    repeat (4) @(negedge clk);
    if (divisions != NUM_DIVISIONS) begin
      run_errors++;
      $display("Only %0d of %0d divisions completed", divisions, NUM_DIVISIONS);
    end
    $display("Closing report: %0d checker errors, %0d run errors, %0d divisions, %0d exact",
             errors, run_errors, divisions, exact_cases);
    if (errors + run_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
logic/div_pkg.sv
logic/div_array.sv
logic/operand_capture.sv
logic/div_ctrl.sv
logic/result_hold.sv
logic/approx_div_top.sv
test/div_checker.sv
test/tb_approx_div.sv

// ==== Bender.yml ====
package:
  name: approx_div

sources:
  - logic/div_pkg.sv
  - logic/div_array.sv
  - logic/operand_capture.sv
  - logic/div_ctrl.sv
  - logic/result_hold.sv
  - logic/approx_div_top.sv
  - target: test
    files:
      - test/div_checker.sv
      - test/tb_approx_div.sv
